// ==== Makefile ====
TOOL       = verilator
TOP        = pad_reader_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
COMMON     = --timing --timescale 1ns/10ps
FLAGS      = --binary --assert $(COMMON)
LINT_FLAGS = --lint-only $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
logic/pad_pkg.sv
logic/phase_timer.sv
logic/pad_sequencer.sv
logic/pin_sampler.sv
logic/pad_reader_top.sv
tb/pad_reader_checker.sv
tb/pad_reader_tb.sv

// ==== logic/pad_pkg.sv ====
`default_nettype none

package pad_pkg;

    // ------------------------------
    // read timing
    // ------------------------------
    localparam int num_phases           = 8;
    localparam int phase_cycles_default = 1000;  // matches pad timing at a typical board clock
    localparam int count_w              = 12;    // covers phase_cycles_default

    // select is high in the even phases and low in the odd ones
    typedef enum logic [2:0] {
        phase_0 = 3'd0,
        phase_1 = 3'd1,
        phase_2 = 3'd2,
        phase_3 = 3'd3,
        phase_4 = 3'd4,
        phase_5 = 3'd5,
        phase_6 = 3'd6,
        phase_7 = 3'd7
    } phase_t;

    // ------------------------------
    // pad connector and report
    // ------------------------------
    typedef struct packed {
        logic up_z;
        logic down_y;
        logic left_x;
        logic right_mode;
        logic a_b;
        logic start_c;
    } pad_pins_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic c;
        logic x;
        logic y;
        logic z;
        logic start;
        logic mode;
    } pad_buttons_t;

    typedef struct packed {
        logic         connected;
        logic         six_button;
        pad_buttons_t buttons;      // pressed flags, active high
    } pad_report_t;

endpackage

`default_nettype wire

// ==== logic/pad_reader_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pad_reader_top #(
    parameter int phase_cycles = pad_pkg::phase_cycles_default
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 poll,
    input  wire pad_pkg::pad_pins_t   pins,
    output logic                      select,
    output logic                      busy,
    output logic                      report_valid,
    output pad_pkg::pad_report_t      report
);
    import pad_pkg::*;

    logic   timer_start;
    logic   timer_run;
    logic   phase_end;
    logic   read_start;
    logic   read_end;
    phase_t phase;

    phase_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .start     (timer_start),
        .run       (timer_run),
        .length    (count_w'(phase_cycles)),
        .phase_end (phase_end)
    );

    pad_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .poll         (poll),
        .phase_end    (phase_end),
        .timer_start  (timer_start),
        .timer_run    (timer_run),
        .select       (select),
        .busy         (busy),
        .report_valid (report_valid),
        .read_start   (read_start),
        .read_end     (read_end),
        .phase        (phase)
    );

    pin_sampler u_sampler (
        .clk        (clk),
        .reset      (reset),
        .pins       (pins),
        .phase      (phase),
        .phase_end  (phase_end),
        .read_start (read_start),
        .read_end   (read_end),
        .report     (report)
    );

endmodule

`default_nettype wire

// ==== logic/pad_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pad_sequencer (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       poll,
    input  wire logic       phase_end,
    output logic            timer_start,
    output logic            timer_run,
    output logic            select,
    output logic            busy,
    output logic            report_valid,
    output logic            read_start,
    output logic            read_end,
    output pad_pkg::phase_t phase
);
    import pad_pkg::*;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_run    = 2'd1,
        st_finish = 2'd2
    } state_t;

    localparam phase_t last_phase = phase_t'(3'(num_phases - 1));

    state_t     state;
    logic [2:0] phase_next;

    // ------------------------------
    // strobes decoded from the state
    // ------------------------------
    assign read_start  = (state == st_idle) && poll;  // a poll outside idle is dropped
    assign timer_start = read_start;
    assign timer_run   = (state == st_run);
    assign read_end    = (state == st_finish);

    assign phase_next = phase + 3'd1;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= st_idle;
            phase        <= phase_0;
            select       <= 1'b1;
            busy         <= 1'b0;
            report_valid <= 1'b0;
        end else begin
            report_valid <= 1'b0;
            case (state)
                st_idle: begin
                    select <= 1'b1;
                    if (poll) begin
                        state <= st_run;
                        phase <= phase_0;
                        busy  <= 1'b1;
                    end
                end
                st_run: begin
                    if (phase_end) begin
                        if (phase == last_phase) begin
                            state  <= st_finish;
                            select <= 1'b1;
                        end else begin
                            phase  <= phase_t'(phase_next);
                            select <= ~phase_next[0];  // even phases drive select high
                        end
                    end
                end
                st_finish: begin
                    // the sampler copies its result to the report on this edge
                    state        <= st_idle;
                    busy         <= 1'b0;
                    report_valid <= 1'b1;
                end
                default: begin
                    state  <= st_idle;
                    select <= 1'b1;
                    busy   <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/phase_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_timer (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         start,
    input  wire logic                         run,
    input  wire logic [pad_pkg::count_w-1:0]  length,
    output logic                              phase_end
);
    import pad_pkg::*;

    logic [count_w-1:0] count;

    // last cycle of the phase
    assign phase_end = run && (count == length - 1'b1);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (run) begin
            if (phase_end) begin
                count <= '0;  // next phase starts straight away
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pin_sampler.sv ====
`timescale 1ns/10ps
`default_nettype none

module pin_sampler (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire pad_pkg::pad_pins_t   pins,
    input  wire pad_pkg::phase_t      phase,
    input  wire logic                 phase_end,
    input  wire logic                 read_start,
    input  wire logic                 read_end,
    output pad_pkg::pad_report_t      report
);
    import pad_pkg::*;

    pad_pins_t   pins_meta;
    pad_pins_t   pins_sync;
    pad_pins_t   low;          // pins driven low by the pad, as active high
    pad_report_t work;
    pad_report_t result;

    // ------------------------------
    // synchronizer
    // ------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pins_meta <= '1;  // idle pins float high
            pins_sync <= '1;
        end else begin
            pins_meta <= pins;
            pins_sync <= pins_meta;
        end
    end

    assign low = ~pins_sync;

    // ------------------------------
    // capture per phase
    // ------------------------------
    always_ff @(posedge clk) begin
        if (read_start) begin
            work <= '0;
        end else if (phase_end) begin
            case (phase)
                phase_1: begin
                    work.buttons.a     <= low.a_b;
                    work.buttons.start <= low.start_c;
                    work.connected     <= low.left_x & low.right_mode;
                end
                phase_2: begin
                    work.buttons.up    <= low.up_z;
                    work.buttons.down  <= low.down_y;
                    work.buttons.left  <= low.left_x;
                    work.buttons.right <= low.right_mode;
                end
                phase_4: begin
                    work.buttons.b <= low.a_b;
                    work.buttons.c <= low.start_c;
                end
                phase_5: work.six_button <= low.up_z & low.down_y & low.left_x & low.right_mode;
                phase_6: begin
                    work.buttons.z    <= low.up_z;
                    work.buttons.y    <= low.down_y;
                    work.buttons.x    <= low.left_x;
                    work.buttons.mode <= low.right_mode;
                end
                default: ;
            endcase
        end
    end

    // a three-button pad shows directions again in phase 6, so those bits are dropped
    always_comb begin
        result            = work;
        result.six_button = work.connected & work.six_button;
        if (!result.six_button) begin
            result.buttons.x    = 1'b0;
            result.buttons.y    = 1'b0;
            result.buttons.z    = 1'b0;
            result.buttons.mode = 1'b0;
        end
        if (!work.connected) begin
            result.buttons = '0;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            report <= '0;
        end else if (read_end) begin
            report <= result;
        end
    end

endmodule

`default_nettype wire

// ==== tb/pad_golden.txt ====
// kind (0 none, 3 three-button, 6 six-button), pressed mask, expected report, extra poll
// mask bits from 11 down: up down left right a b c x y z start mode
6 000 3000 0
6 fff 3fff 0
6 800 3800 0
6 080 3080 0
6 010 3010 0
6 001 3001 0
6 5a5 35a5 1
6 a5a 3a5a 0
6 002 3002 0
6 01c 301c 0
6 123 3123 1
6 c40 3c40 0
3 000 2000 0
3 01d 2000 0
3 8e2 28e2 0
3 5ff 25e2 1
3 a3d 2a20 0
3 340 2340 0
3 4c3 24c2 0
0 000 0000 0
0 fff 0000 0
0 5a5 0000 1
6 7f7 37f7 0

// ==== tb/pad_reader_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pad_reader_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic timer_start,
    input wire logic phase_end,
    input wire logic select,
    input wire logic busy,
    input wire logic report_valid
);

    logic [3:0]  ends_seen;  // phase_end strobes since the read began
    int unsigned failures = 0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ends_seen <= '0;
        end else if (timer_start) begin
            ends_seen <= '0;
        end else if (phase_end) begin
            ends_seen <= ends_seen + 1'b1;
        end
    end

    report_valid_single: assert property (
        @(posedge clk) disable iff (!reset) report_valid |=> !report_valid
    ) else begin
        failures = failures + 1;
        $error("report_valid stayed high for more than one cycle");
    end

    select_high_when_idle: assert property (
        @(posedge clk) disable iff (!reset) !busy |-> select
    ) else begin
        failures = failures + 1;
        $error("select is low while the reader is idle");
    end

    // busy drops one cycle after the last phase, so the count is complete here
    eight_phases_per_read: assert property (
        @(posedge clk) disable iff (!reset) $fell(busy) |-> (ends_seen == 4'd8)
    ) else begin
        failures = failures + 1;
        $error("a read ended after %0d phases", ends_seen);
    end

endmodule

bind pad_sequencer pad_reader_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .timer_start  (timer_start),
    .phase_end    (phase_end),
    .select       (select),
    .busy         (busy),
    .report_valid (report_valid)
);

`default_nettype wire

// ==== tb/pad_reader_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pad_reader_tb;
    import pad_pkg::*;

    localparam int phase_cycles = 8;
    localparam int read_cycles  = num_phases * phase_cycles + 1;  // poll edge to report_valid
    localparam int slack_cycles = 20;
    localparam int reset_cycles = 10;

    typedef struct packed {
        logic [3:0]   kind;    // 0 no pad, 3 three-button, 6 six-button
        pad_buttons_t mask;
        pad_report_t  report;
        logic         extra;   // poll again while the read runs
    } golden_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         poll;
    pad_pins_t    pins;
    logic         select;
    logic         busy;
    logic         report_valid;
    pad_report_t  report;

    logic [3:0]   kind;
    pad_buttons_t mask;
    int           falls = 0;
    int           watchdog_cycles = 0;
    golden_t      lines[$];

    pad_reader_top #(.phase_cycles(phase_cycles)) DUT (
        .clk          (clk),
        .reset        (reset),
        .poll         (poll),
        .pins         (pins),
        .select       (select),
        .busy         (busy),
        .report_valid (report_valid),
        .report       (report)
    );

    always #5 clk = ~clk;

    // ------------------------------
    // pad model
    // ------------------------------
    function automatic pad_pins_t pad_pins(input logic [3:0] kind_now, input pad_buttons_t b,
                                           input logic sel, input int falls_now);
        pad_pins_t low;  // pins pulled low, as active high
        int        ph;
        ph = sel ? 2 * falls_now : 2 * falls_now - 1;
        if (sel) begin
            if (kind_now == 4'd6 && ph == 6) begin
                low = '{up_z: b.z, down_y: b.y, left_x: b.x, right_mode: b.mode,
                        a_b: b.b, start_c: b.c};
            end else begin
                low = '{b.up, b.down, b.left, b.right, b.b, b.c};
            end
        end else if (kind_now == 4'd6 && ph == 5) begin
            low = '{1'b1, 1'b1, 1'b1, 1'b1, b.a, b.start};  // six-button id phase
        end else begin
            low = '{b.up, b.down, 1'b1, 1'b1, b.a, b.start};
        end
        if (kind_now == 4'd0) begin
            low = '0;  // nothing plugged in, every pin floats high
        end
        return pad_pins_t'(~low);
    endfunction

    // the pad steps its phase on each fall of select and restarts when a read begins
    always @(negedge select or posedge busy) begin
        if (select) begin
            falls = 0;
        end else begin
            falls = falls + 1;
        end
    end

    always_comb pins = pad_pins(kind, mask, select, falls);

    // ------------------------------
    // expected values and checks
    // ------------------------------
    function automatic pad_report_t expected_report(input logic [3:0] kind_now,
                                                    input pad_buttons_t pressed);
        pad_report_t r;
        r = '0;
        if (kind_now != 4'd0) begin
            r.connected = 1'b1;
            r.buttons   = pressed;
            if (kind_now == 4'd6) begin
                r.six_button = 1'b1;
            end else begin
                // a three-button pad has no x, y, z or mode
                r.buttons.x    = 1'b0;
                r.buttons.y    = 1'b0;
                r.buttons.z    = 1'b0;
                r.buttons.mode = 1'b0;
            end
        end
        return r;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, want);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_golden();
        int      fd;
        int      fields;
        int      kind_in;
        int      mask_in;
        int      report_in;
        int      extra_in;
        string   text;
        golden_t g;
        fd = $fopen("tb/pad_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file tb/pad_golden.txt");
            $display(">>> FAIL");
            $fatal(1, "golden file missing");
        end else begin
            while (!$feof(fd)) begin
                text   = "";
                fields = $fgets(text, fd);
                fields = $sscanf(text, "%d %h %h %d", kind_in, mask_in, report_in, extra_in);
                if (fields == 4) begin  // comment and blank lines give fewer fields
                    g.kind   = 4'(kind_in);
                    g.mask   = pad_buttons_t'(12'(mask_in));
                    g.report = pad_report_t'(14'(report_in));
                    g.extra  = extra_in[0];
                    lines.push_back(g);
                end
            end
            $fclose(fd);
            if (lines.size() == 0) begin
                $display("the golden file holds no reads");
                $display(">>> FAIL");
                $fatal(1, "empty golden file");
            end
        end
    endtask

    task automatic run_read(input golden_t g, input int idx);
        pad_report_t want;
        int          cycles;
        want = expected_report(g.kind, g.mask);
        check(32'(g.report), 32'(want), $sformatf("golden line %0d against the pad rules", idx));
        kind = g.kind;
        mask = g.mask;
        poll = 1'b1;
        @(posedge clk);
        #1;
        poll   = 1'b0;
        cycles = 0;
        check(32'(busy), 32'd1, "busy after poll");
        while (!report_valid) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            poll   = g.extra && (cycles == 3 * phase_cycles + 2);  // lands in phase 3
            if (!report_valid) begin
                check(32'(busy), 32'd1, "busy during the read");
            end
        end
        check(32'(cycles), 32'(read_cycles), "report_valid delay after poll");
        check(32'(busy), 32'd0, "busy at report_valid");
        check(32'(select), 32'd1, "select at report_valid");
        check(32'(report), 32'(want), $sformatf("report of read %0d", idx));
        repeat (3) begin
            @(posedge clk);
            #1;
            check(32'(report_valid), 32'd0, "report_valid after the strobe");
            check(32'(busy), 32'd0, "busy after the strobe");
            check(32'(report), 32'(want), "report held after the strobe");
        end
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin
        reset = 1'b0;
        poll  = 1'b0;
        kind  = 4'd0;
        mask  = '0;
        read_golden();
        watchdog_cycles = reset_cycles + 2
                        + lines.size() * (num_phases * phase_cycles + slack_cycles);
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        @(posedge clk);
        #1;
        check(32'(select), 32'd1, "select after reset");
        check(32'(busy), 32'd0, "busy after reset");
        check(32'(report_valid), 32'd0, "report_valid after reset");
        check(32'(report), 32'd0, "report after reset");
        foreach (lines[i]) begin
            run_read(lines[i], i);
        end
        $display(">>> PASS");
        $finish;
    end

    always @(DUT.u_sequencer.u_checker.failures) begin
        if (DUT.u_sequencer.u_checker.failures != 0) begin
            $display("an assertion on the sequencer failed at %0t", $time);
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired at %0t before a report arrived", $time);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
